// ==== Bender.yml ====
package:
  name: pixel_renderer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/render_pkg.sv
      - hw/anim_timer.sv
      - hw/sprite_rom.sv
      - hw/sprite_hit.sv
      - hw/tile_lookup.sv
      - hw/pixel_compose.sv
      - hw/pixel_renderer.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_pixel_renderer.sv

// ==== flist.f ====
+incdir+include
hw/render_pkg.sv
hw/anim_timer.sv
hw/sprite_rom.sv
hw/sprite_hit.sv
hw/tile_lookup.sv
hw/pixel_compose.sv
hw/pixel_renderer.sv
test/tb_pixel_renderer.sv

// ==== hw/anim_timer.sv ====
`timescale 1ns/1ps
`include "render_config.svh"

module anim_timer (
    input  logic clk,
    input  logic arst_n,
    input  logic frame_start,
    output logic player_frame,
    output logic ghost_frame
);

    // channel 0 drives the player and channel 1 the ghosts
    for (genvar i = 0; i < 2; i++) begin : g_chan
        localparam int LIMIT = (i == 0) ? `ANIM_PLAYER_FRAMES : `ANIM_GHOST_FRAMES;
        localparam int CNT_W = (LIMIT > 1) ? $clog2(LIMIT) : 1;

        logic [CNT_W-1:0] cnt_q;
        logic             frame_q;

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                cnt_q   <= '0;
                frame_q <= 1'b0;
            end else if (frame_start) begin
                if (cnt_q == CNT_W'(LIMIT - 1)) begin
                    cnt_q   <= '0;
                    frame_q <= ~frame_q;
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    end

    assign player_frame = g_chan[0].frame_q;
    assign ghost_frame  = g_chan[1].frame_q;

endmodule

// ==== hw/pixel_compose.sv ====
`timescale 1ns/1ps
`include "render_config.svh"

module pixel_compose (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    valid,
    input  logic                    display,
    input  logic                    wall,
    input  logic                    dot,
    input  logic                    big_dot,
    input  render_pkg::offset_t     tile_x,
    input  render_pkg::offset_t     tile_y,
    input  render_pkg::sprite_sel_e sel,
    input  logic                    sprite_bit,
    input  render_pkg::game_state_e game_state,
    output logic                    rgb_valid,
    output render_pkg::rgb_t        rgb
);
    import render_pkg::*;

    rgb_t sprite_color;
    rgb_t color_d;
    logic dot_bit;
    logic big_dot_bit;

    sprite_rom dot_rom_i (
        .player_frame (1'b0),
        .ghost_frame  (1'b0),
        .sprite_x     ('0),
        .sprite_y     ('0),
        .tile_x       (tile_x),
        .tile_y       (tile_y),
        .player_bit   (),
        .ghost_bit    (),
        .dot_bit      (dot_bit),
        .big_dot_bit  (big_dot_bit)
    );

    always_comb begin
        case (sel)
            sel_player: sprite_color = `COLOR_PLAYER;
            sel_ghost0: sprite_color = `COLOR_GHOST0;
            sel_ghost1: sprite_color = `COLOR_GHOST1;
            sel_ghost2: sprite_color = `COLOR_GHOST2;
            sel_ghost3: sprite_color = `COLOR_GHOST3;
            default:    sprite_color = `COLOR_BG;
        endcase
    end

    // transparent sprite pixels show the background and never a dot
    always_comb begin
        if (!display) begin
            color_d = '0;
        end else if (!(game_state inside {state_playing, state_win, state_gameover})) begin
            color_d = `COLOR_DEBUG;
        end else if (wall) begin
            color_d = `COLOR_WALL;
        end else if (sel != sel_none) begin
            color_d = sprite_bit ? sprite_color : rgb_t'(`COLOR_BG);
        end else if (big_dot) begin
            color_d = big_dot_bit ? rgb_t'(`COLOR_DOT) : rgb_t'(`COLOR_BG);
        end else if (dot) begin
            color_d = dot_bit ? rgb_t'(`COLOR_DOT) : rgb_t'(`COLOR_BG);
        end else begin
            color_d = `COLOR_BG;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rgb_valid <= 1'b0;
            rgb       <= '0;
        end else begin
            rgb_valid <= valid;
            if (valid) begin
                rgb <= color_d;
            end
        end
    end

endmodule

// ==== hw/pixel_renderer.sv ====
`timescale 1ns/1ps
`include "render_config.svh"

module pixel_renderer (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    pix_valid,
    input  render_pkg::pixel_t      pix,
    input  logic                    frame_start,
    input  render_pkg::game_state_e game_state,
    input  render_pkg::tilemap_t    tiles,
    input  render_pkg::sprite_t     player,
    input  render_pkg::sprite_t     ghosts [`NUM_GHOSTS],
    output logic                    rgb_valid,
    output render_pkg::rgb_t        rgb
);
    import render_pkg::*;

    logic        player_frame;
    logic        ghost_frame;

    // stage 1 results
    logic        s1_valid;
    logic        s1_display;
    logic        s1_wall;
    logic        s1_dot;
    logic        s1_big_dot;
    offset_t     s1_tile_x;
    offset_t     s1_tile_y;
    sprite_sel_e s1_sel;
    logic        s1_sprite_bit;

    anim_timer anim_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .frame_start  (frame_start),
        .player_frame (player_frame),
        .ghost_frame  (ghost_frame)
    );

    tile_lookup tile_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .pix_valid (pix_valid),
        .pix       (pix),
        .tiles     (tiles),
        .valid     (s1_valid),
        .display   (s1_display),
        .wall      (s1_wall),
        .dot       (s1_dot),
        .big_dot   (s1_big_dot),
        .tile_x    (s1_tile_x),
        .tile_y    (s1_tile_y)
    );

    sprite_hit hit_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .pix_valid    (pix_valid),
        .pix          (pix),
        .player       (player),
        .ghosts       (ghosts),
        .player_frame (player_frame),
        .ghost_frame  (ghost_frame),
        .sel          (s1_sel),
        .sprite_bit   (s1_sprite_bit)
    );

    pixel_compose compose_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .valid      (s1_valid),
        .display    (s1_display),
        .wall       (s1_wall),
        .dot        (s1_dot),
        .big_dot    (s1_big_dot),
        .tile_x     (s1_tile_x),
        .tile_y     (s1_tile_y),
        .sel        (s1_sel),
        .sprite_bit (s1_sprite_bit),
        .game_state (game_state),
        .rgb_valid  (rgb_valid),
        .rgb        (rgb)
    );

endmodule

// ==== hw/render_pkg.sv ====
`include "render_config.svh"

package render_pkg;

    typedef enum logic [2:0] {
        state_idle     = 3'd0,
        state_playing  = 3'd1,
        state_win      = 3'd2,
        state_gameover = 3'd3
    } game_state_e;

    typedef enum logic [1:0] {
        dir_right = 2'd0,
        dir_left  = 2'd1,
        dir_up    = 2'd2,
        dir_down  = 2'd3
    } dir_e;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // one pixel from the display timing generator
    typedef struct packed {
        logic                       display;
        logic [`SCREEN_W_LOG2-1:0]  x;
        logic [`SCREEN_H_LOG2-1:0]  y;
    } pixel_t;

    // x and y give the top left corner of the sprite box
    typedef struct packed {
        logic [`SCREEN_W_LOG2-1:0]  x;
        logic [`SCREEN_H_LOG2-1:0]  y;
        dir_e                       dir;
    } sprite_t;

    // bit index is column plus row times the column count
    typedef struct packed {
        logic [`TILE_COLS*`TILE_ROWS-1:0] walls;
        logic [`TILE_COLS*`TILE_ROWS-1:0] dots;
        logic [`TILE_COLS*`TILE_ROWS-1:0] big_dots;
    } tilemap_t;

    typedef logic [`TILE_SIZE_LOG2-1:0] offset_t;

    typedef enum logic [2:0] {
        sel_none   = 3'd0,
        sel_player = 3'd1,
        sel_ghost0 = 3'd2,
        sel_ghost1 = 3'd3,
        sel_ghost2 = 3'd4,
        sel_ghost3 = 3'd5
    } sprite_sel_e;

endpackage

// ==== hw/sprite_hit.sv ====
`timescale 1ns/1ps
`include "render_config.svh"

module sprite_hit (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    pix_valid,
    input  render_pkg::pixel_t      pix,
    input  render_pkg::sprite_t     player,
    input  render_pkg::sprite_t     ghosts [`NUM_GHOSTS],
    input  logic                    player_frame,
    input  logic                    ghost_frame,
    output render_pkg::sprite_sel_e sel,
    output logic                    sprite_bit
);
    import render_pkg::*;

    localparam offset_t LAST = offset_t'(`TILE_SIZE - 1);

    sprite_sel_e sel_d;
    offset_t     off_x;
    offset_t     off_y;
    offset_t     rom_x;
    offset_t     rom_y;
    logic        player_bit;
    logic        ghost_bit;
    logic        bit_d;

    function automatic logic covers(pixel_t p, sprite_t s);
        logic [`SCREEN_W_LOG2-1:0] dx;
        logic [`SCREEN_H_LOG2-1:0] dy;
        dx = p.x - s.x;
        dy = p.y - s.y;
        return (p.x >= s.x) && (p.y >= s.y) && (dx < `TILE_SIZE) && (dy < `TILE_SIZE);
    endfunction

    function automatic void rotate(input offset_t x, input offset_t y, input dir_e dir,
                                   output offset_t rx, output offset_t ry);
        case (dir)
            dir_left: begin
                rx = LAST - x;
                ry = y;
            end
            dir_up: begin
                rx = LAST - y;
                ry = x;
            end
            dir_down: begin
                rx = y;
                ry = LAST - x;
            end
            default: begin
                rx = x;
                ry = y;
            end
        endcase
    endfunction

    always_comb begin
        sel_d = sel_none;
        off_x = '0;
        off_y = '0;
        // walk the ghosts backwards so the lowest index wins an overlap
        for (int g = `NUM_GHOSTS - 1; g >= 0; g--) begin
            if (covers(pix, ghosts[g])) begin
                sel_d = sprite_sel_e'(int'(sel_ghost0) + g);
                off_x = offset_t'(pix.x - ghosts[g].x);
                off_y = offset_t'(pix.y - ghosts[g].y);
            end
        end
        if (covers(pix, player)) begin
            sel_d = sel_player;
            off_x = offset_t'(pix.x - player.x);
            off_y = offset_t'(pix.y - player.y);
        end
    end

    // only the player turns with its heading
    always_comb begin
        rom_x = off_x;
        rom_y = off_y;
        if (sel_d == sel_player) begin
            rotate(off_x, off_y, player.dir, rom_x, rom_y);
        end
    end

    sprite_rom rom_i (
        .player_frame (player_frame),
        .ghost_frame  (ghost_frame),
        .sprite_x     (rom_x),
        .sprite_y     (rom_y),
        .tile_x       ('0),
        .tile_y       ('0),
        .player_bit   (player_bit),
        .ghost_bit    (ghost_bit),
        .dot_bit      (),
        .big_dot_bit  ()
    );

    always_comb begin
        case (sel_d)
            sel_none:   bit_d = 1'b0;
            sel_player: bit_d = player_bit;
            default:    bit_d = ghost_bit;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sel        <= sel_none;
            sprite_bit <= 1'b0;
        end else if (pix_valid) begin
            sel        <= pix.display ? sel_d : sel_none;
            sprite_bit <= bit_d;
        end
    end

endmodule

// ==== hw/sprite_rom.sv ====
`timescale 1ns/1ps
`include "render_config.svh"

module sprite_rom (
    input  logic                player_frame,
    input  logic                ghost_frame,
    input  render_pkg::offset_t sprite_x,
    input  render_pkg::offset_t sprite_y,
    input  render_pkg::offset_t tile_x,
    input  render_pkg::offset_t tile_y,
    output logic                player_bit,
    output logic                ghost_bit,
    output logic                dot_bit,
    output logic                big_dot_bit
);
    import render_pkg::*;

    localparam offset_t LAST = offset_t'(`TILE_SIZE - 1);
    localparam offset_t HALF = offset_t'(`TILE_SIZE / 2);

    logic mouth;
    logic corner;
    logic skirt_gap;

    function automatic logic in_band(offset_t v, offset_t lo, offset_t hi);
        return (v >= lo) && (v <= hi);
    endfunction

    // the mouth opens to the right and sprite_hit turns the offset to the heading
    assign mouth = (sprite_x >= HALF) && in_band(sprite_y, HALF - 1, HALF);

    assign corner = ((sprite_x == '0) || (sprite_x == LAST)) &&
                    ((sprite_y == '0) || (sprite_y == LAST));

    // frame 1 closes the mouth and rounds the body off
    assign player_bit = player_frame ? !corner : !mouth;

    // bottom row gaps move between odd and even columns
    assign skirt_gap = (sprite_y == LAST) && (sprite_x[0] != ghost_frame);
    assign ghost_bit = !skirt_gap;

    assign dot_bit = in_band(tile_x, HALF - 1, HALF) &&
                     in_band(tile_y, HALF - 1, HALF);

    assign big_dot_bit = in_band(tile_x, HALF - 2, HALF + 1) &&
                         in_band(tile_y, HALF - 2, HALF + 1);

endmodule

// ==== hw/tile_lookup.sv ====
`timescale 1ns/1ps
`include "render_config.svh"

module tile_lookup (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 pix_valid,
    input  render_pkg::pixel_t   pix,
    input  render_pkg::tilemap_t tiles,
    output logic                 valid,
    output logic                 display,
    output logic                 wall,
    output logic                 dot,
    output logic                 big_dot,
    output render_pkg::offset_t  tile_x,
    output render_pkg::offset_t  tile_y
);

    localparam int IDX_W = $clog2(`TILE_COLS * `TILE_ROWS);

    logic [`SCREEN_W_LOG2-`TILE_SIZE_LOG2-1:0] col;
    logic [`SCREEN_H_LOG2-`TILE_SIZE_LOG2-1:0] row;
    logic [IDX_W-1:0]                          idx;

    assign col = pix.x[`SCREEN_W_LOG2-1:`TILE_SIZE_LOG2];
    assign row = pix.y[`SCREEN_H_LOG2-1:`TILE_SIZE_LOG2];

    // tile maps are stored row after row
    assign idx = IDX_W'(col) + IDX_W'(row) * IDX_W'(`TILE_COLS);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid   <= 1'b0;
            display <= 1'b0;
        end else begin
            valid   <= pix_valid;
            display <= pix_valid & pix.display;
        end
    end

    always_ff @(posedge clk) begin
        if (pix_valid) begin
            wall    <= tiles.walls[idx];
            dot     <= tiles.dots[idx];
            big_dot <= tiles.big_dots[idx];
            tile_x  <= pix.x[`TILE_SIZE_LOG2-1:0];
            tile_y  <= pix.y[`TILE_SIZE_LOG2-1:0];
        end
    end

endmodule

// ==== include/render_config.svh ====
`ifndef RENDER_CONFIG_SVH
`define RENDER_CONFIG_SVH

// screen geometry, a grid of square tiles
`define TILE_SIZE           8
`define TILE_SIZE_LOG2      3
`define TILE_COLS           8
`define TILE_ROWS           8
`define SCREEN_W_LOG2       6
`define SCREEN_H_LOG2       6

`define NUM_GHOSTS          4

// frame pulses between two animation frame flips
`define ANIM_PLAYER_FRAMES  2
`define ANIM_GHOST_FRAMES   3

// cycles from pix_valid to rgb_valid
`define RENDER_LATENCY      2

// colours are 12 bit, red in the top nibble
`define COLOR_BG            12'h000
`define COLOR_WALL          12'h00f
`define COLOR_DOT           12'hfff
`define COLOR_PLAYER        12'hff0
`define COLOR_GHOST0        12'hf00
`define COLOR_GHOST1        12'hfbf
`define COLOR_GHOST2        12'h0ff
`define COLOR_GHOST3        12'hfb0

// shown for any game state the renderer does not know
`define COLOR_DEBUG         12'h74f

`endif

// ==== include/tb_render_model.svh ====
`ifndef TB_RENDER_MODEL_SVH
`define TB_RENDER_MODEL_SVH

// expected pixel colours, worked out from the rendering rules of the renderer

function automatic logic player_mask(int x, int y, logic frame);
    logic mouth;
    logic corner;
    mouth  = (x >= 4) && (y == 3 || y == 4);
    corner = (x == 0 || x == 7) && (y == 0 || y == 7);
    if (frame) begin
        return !corner;
    end
    return !mouth;
endfunction

function automatic logic ghost_mask(int x, int y, logic frame);
    // frame 0 leaves the odd columns of the bottom row dark, frame 1 the even ones
    if (y != 7) begin
        return 1'b1;
    end
    return frame ? (x % 2 == 1) : (x % 2 == 0);
endfunction

function automatic logic dot_mask(int x, int y);
    return (x >= 3) && (x <= 4) && (y >= 3) && (y <= 4);
endfunction

function automatic logic big_dot_mask(int x, int y);
    return (x >= 2) && (x <= 5) && (y >= 2) && (y <= 5);
endfunction

function automatic logic in_box(pixel_t p, sprite_t s);
    int dx;
    int dy;
    dx = int'(p.x) - int'(s.x);
    dy = int'(p.y) - int'(s.y);
    return (dx >= 0) && (dx < `TILE_SIZE) && (dy >= 0) && (dy < `TILE_SIZE);
endfunction

// maps the offset inside the player box to the offset of the right facing image
function automatic void rotate_heading(input int x, input int y, input dir_e dir,
                                       output int rx, output int ry);
    case (dir)
        dir_left: begin
            rx = 7 - x;
            ry = y;
        end
        dir_up: begin
            rx = 7 - y;
            ry = x;
        end
        dir_down: begin
            rx = y;
            ry = 7 - x;
        end
        default: begin
            rx = x;
            ry = y;
        end
    endcase
endfunction

function automatic rgb_t ghost_color(int g);
    case (g)
        0:       return `COLOR_GHOST0;
        1:       return `COLOR_GHOST1;
        2:       return `COLOR_GHOST2;
        default: return `COLOR_GHOST3;
    endcase
endfunction

function automatic rgb_t expected_color(pixel_t p, game_state_e st, tilemap_t t, sprite_t pl,
                                        sprite_t gh [`NUM_GHOSTS], logic pf, logic gf);
    int idx;
    int tx;
    int ty;
    int rx;
    int ry;
    int pick;
    if (!p.display) begin
        return 12'h000;
    end
    if (!(st == state_playing || st == state_win || st == state_gameover)) begin
        return `COLOR_DEBUG;
    end
    idx = int'(p.x) / `TILE_SIZE + (int'(p.y) / `TILE_SIZE) * `TILE_COLS;
    tx  = int'(p.x) % `TILE_SIZE;
    ty  = int'(p.y) % `TILE_SIZE;
    if (t.walls[idx]) begin
        return `COLOR_WALL;
    end
    if (in_box(p, pl)) begin
        rotate_heading(int'(p.x) - int'(pl.x), int'(p.y) - int'(pl.y), pl.dir, rx, ry);
        if (player_mask(rx, ry, pf)) begin
            return `COLOR_PLAYER;
        end
        return `COLOR_BG;
    end
    pick = -1;
    for (int g = 0; g < `NUM_GHOSTS; g++) begin
        if (pick < 0 && in_box(p, gh[g])) begin
            pick = g;
        end
    end
    if (pick >= 0) begin
        if (ghost_mask(int'(p.x) - int'(gh[pick].x), int'(p.y) - int'(gh[pick].y), gf)) begin
            return ghost_color(pick);
        end
        return `COLOR_BG;
    end
    if (t.big_dots[idx]) begin
        return big_dot_mask(tx, ty) ? `COLOR_DOT : `COLOR_BG;
    end
    if (t.dots[idx]) begin
        return dot_mask(tx, ty) ? `COLOR_DOT : `COLOR_BG;
    end
    return `COLOR_BG;
endfunction

`endif

// ==== test/tb_pixel_renderer.sv ====
`timescale 1ns/1ps
`include "render_config.svh"

module tb_pixel_renderer;
    import render_pkg::*;

    `include "tb_render_model.svh"

    localparam int CLK_HALF      = 50;
    localparam int DRIVE_DELAY   = 1;
    localparam int RESET_CYCLES  = 4;

    // pixel counts of the tests set the timeout
    localparam int RESET_PIXELS  = 4;
    localparam int TILE_PIXELS   = 63 * 64;
    localparam int PLAYER_PIXELS = 4 * 2 * 100;
    localparam int GHOST_PIXELS  = 2 * 24 * 24;
    localparam int STATE_PIXELS  = 4 * 16 * 16 + 1;
    localparam int RANDOM_PIXELS = 300;
    localparam int TOTAL_PIXELS  = RESET_PIXELS + TILE_PIXELS + PLAYER_PIXELS +
                                   GHOST_PIXELS + STATE_PIXELS + RANDOM_PIXELS;
    localparam int MAX_CYCLES    = TOTAL_PIXELS * 2 + 1000;

    typedef struct packed {
        rgb_t        color;
        logic [31:0] due;
        logic [5:0]  x;
        logic [5:0]  y;
    } expect_t;

    logic        clk;
    logic        arst_n;
    logic        pix_valid;
    pixel_t      pix;
    logic        frame_start;
    game_state_e game_state;
    tilemap_t    tiles;
    sprite_t     player;
    sprite_t     ghosts [`NUM_GHOSTS];
    logic        rgb_valid;
    rgb_t        rgb;

    expect_t     exp_q [$];
    int unsigned cycle;
    int          errors;
    int          checks;
    logic [31:0] rng_state;

    // animation state as the testbench expects it
    int          p_count;
    int          g_count;
    logic        p_frame;
    logic        g_frame;

    pixel_renderer dut_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .pix_valid   (pix_valid),
        .pix         (pix),
        .frame_start (frame_start),
        .game_state  (game_state),
        .tiles       (tiles),
        .player      (player),
        .ghosts      (ghosts),
        .rgb_valid   (rgb_valid),
        .rgb         (rgb)
    );

    always #(CLK_HALF) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: the run went past %0d cycles", MAX_CYCLES);
            report_counts();
            $display("test failed");
            $finish;
        end
    end

    // outputs are compared at the falling edge where they are stable
    always @(negedge clk) begin
        expect_t e;
        if (!arst_n) begin
            assert (rgb_valid == 1'b0 && {rgb} == 12'h000) else begin
                errors++;
                $display("Error rgb in reset: rgb_valid 0x%0h, rgb 0x%03h, expected 0x0, 0x000",
                         rgb_valid, {rgb});
            end
        end else if (rgb_valid) begin
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("rgb_valid went high with no pixel in flight at cycle %0d", cycle);
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                checks++;
                assert ({rgb} == {e.color}) else begin
                    errors++;
                    $display("Error rgb: got 0x%03h, expected 0x%03h at pixel (%0d, %0d)",
                             {rgb}, {e.color}, e.x, e.y);
                end
                assert (cycle == e.due) else begin
                    errors++;
                    $display("pixel (%0d, %0d) came out at cycle %0d instead of cycle %0d",
                             e.x, e.y, cycle, e.due);
                end
            end
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic sprite_t random_sprite();
        logic [31:0] r;
        sprite_t     s;
        r     = next_random();
        s.x   = r[5:0];
        s.y   = r[11:6];
        s.dir = dir_e'(r[13:12]);
        return s;
    endfunction

    task automatic report_counts();
        $display("checks: %0d, errors: %0d, pixels left in flight: %0d",
                 checks, errors, exp_q.size());
    endtask

    task automatic advance_anim();
        p_count++;
        if (p_count == `ANIM_PLAYER_FRAMES) begin
            p_count = 0;
            p_frame = !p_frame;
        end
        g_count++;
        if (g_count == `ANIM_GHOST_FRAMES) begin
            g_count = 0;
            g_frame = !g_frame;
        end
    endtask

    // one clock of stimulus
    // the expected colour uses the frame bits from before a pulse in the same cycle
    task automatic drive_cycle(input logic valid, input int x, input int y,
                               input logic disp, input logic pulse);
        expect_t e;
        @(posedge clk);
        #(DRIVE_DELAY);
        pix_valid   = valid;
        pix.display = disp;
        pix.x       = 6'(x);
        pix.y       = 6'(y);
        frame_start = pulse;
        if (valid) begin
            e.color = expected_color(pix, game_state, tiles, player, ghosts, p_frame, g_frame);
            e.due   = cycle + `RENDER_LATENCY;
            e.x     = pix.x;
            e.y     = pix.y;
            exp_q.push_back(e);
        end
        if (pulse) begin
            advance_anim();
        end
    endtask

    // idle cycles until every pixel in flight is back or overdue
    task automatic drain_pipeline();
        int waited;
        waited = 0;
        drive_cycle(1'b0, 0, 0, 1'b0, 1'b0);
        while (exp_q.size() != 0 && waited < `RENDER_LATENCY + 2) begin
            drive_cycle(1'b0, 0, 0, 1'b0, 1'b0);
            waited++;
        end
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%0d pixels never came back from the DUT", exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic pulse_frames(input int n);
        repeat (n) begin
            drive_cycle(1'b0, 0, 0, 1'b0, 1'b1);
        end
        drive_cycle(1'b0, 0, 0, 1'b0, 1'b0);
    endtask

    task automatic scan_rect(input int x0, input int y0, input int w, input int h);
        for (int y = y0; y < y0 + h; y++) begin
            for (int x = x0; x < x0 + w; x++) begin
                drive_cycle(1'b1, x, y, 1'b1, 1'b0);
            end
        end
    endtask

    // sprites are parked in the last tile
    task automatic clear_scene();
        tiles      = '0;
        game_state = state_playing;
        player.x   = 6'd56;
        player.y   = 6'd56;
        player.dir = dir_right;
        for (int g = 0; g < `NUM_GHOSTS; g++) begin
            ghosts[g] = player;
        end
    endtask

    task automatic check_reset_and_blank();
        clear_scene();
        tiles.walls = '1;
        repeat (3) begin
            @(negedge clk);
            assert (rgb_valid == 1'b0) else begin
                errors++;
                $display("Error rgb_valid: got 0x%0h, expected 0x0 after reset", rgb_valid);
            end
            assert ({rgb} == 12'h000) else begin
                errors++;
                $display("Error rgb: got 0x%03h, expected 0x000 after reset", {rgb});
            end
        end
        drive_cycle(1'b1, 9, 9, 1'b0, 1'b0);
        drive_cycle(1'b1, 9, 9, 1'b1, 1'b0);
        drive_cycle(1'b1, 60, 60, 1'b0, 1'b0);
        drive_cycle(1'b1, 30, 40, 1'b1, 1'b0);
        drain_pipeline();
    endtask

    task automatic sweep_tiles();
        clear_scene();
        for (int i = 0; i < `TILE_COLS * `TILE_ROWS; i++) begin
            tiles.walls[i]    = (i % 5 == 0);
            tiles.dots[i]     = (i % 3 != 0);
            tiles.big_dots[i] = (i % 4 == 1);
        end
        for (int i = 0; i < `TILE_COLS * `TILE_ROWS - 1; i++) begin
            scan_rect((i % `TILE_COLS) * `TILE_SIZE, (i / `TILE_COLS) * `TILE_SIZE,
                      `TILE_SIZE, `TILE_SIZE);
        end
        drain_pipeline();
    endtask

    task automatic turn_player();
        clear_scene();
        tiles.dots = '1;
        for (int d = 0; d < 4; d++) begin
            player.x   = 6'd12;
            player.y   = 6'd20;
            player.dir = dir_e'(d);
            scan_rect(11, 19, 10, 10);
            pulse_frames(2);
            scan_rect(11, 19, 10, 10);
            drain_pipeline();
        end
    endtask

    task automatic overlap_ghosts();
        clear_scene();
        tiles.dots         = '1;
        tiles.big_dots[18] = 1'b1;
        tiles.walls[27]    = 1'b1;
        player.x = 6'd16;
        player.y = 6'd16;
        player.dir = dir_right;
        ghosts[0] = '{x: 6'd20, y: 6'd18, dir: dir_up};
        ghosts[1] = '{x: 6'd22, y: 6'd20, dir: dir_left};
        ghosts[2] = '{x: 6'd30, y: 6'd20, dir: dir_down};
        ghosts[3] = '{x: 6'd26, y: 6'd26, dir: dir_right};
        scan_rect(14, 14, 24, 24);
        pulse_frames(3);
        scan_rect(14, 14, 24, 24);
        drain_pipeline();
    endtask

    // keeps the scene of the ghost test and changes only the game state
    task automatic switch_game_state();
        logic [2:0] codes [4];
        codes = '{3'd0, 3'd6, 3'd2, 3'd3};
        for (int i = 0; i < 4; i++) begin
            game_state = game_state_e'(codes[i]);
            scan_rect(16, 16, 16, 16);
            if (i == 0) begin
                drive_cycle(1'b1, 20, 20, 1'b0, 1'b0);
            end
            drain_pipeline();
        end
        game_state = state_playing;
    endtask

    task automatic random_sweep();
        logic [31:0] r;
        sprite_t     anchor;
        int          sent;
        int          s;
        int          x;
        int          y;
        repeat (3) begin
            tiles.walls    = {next_random() & next_random(), next_random() & next_random()};
            tiles.dots     = {next_random(), next_random()};
            tiles.big_dots = {next_random() & next_random(), next_random() & next_random()};
            player = random_sprite();
            for (int g = 0; g < `NUM_GHOSTS; g++) begin
                ghosts[g] = random_sprite();
            end
            game_state = state_playing;
            sent = 0;
            while (sent < RANDOM_PIXELS / 3) begin
                r = next_random();
                // half of the pixels land on or near a sprite
                if (r[8]) begin
                    s = int'(r[11:9]) % (`NUM_GHOSTS + 1);
                    if (s == 0) begin
                        anchor = player;
                    end else begin
                        anchor = ghosts[s - 1];
                    end
                    x = (int'(anchor.x) + int'(r[15:12]) - 3) & 63;
                    y = (int'(anchor.y) + int'(r[19:16]) - 3) & 63;
                end else begin
                    x = int'(r[25:20]);
                    y = int'(r[31:26]);
                end
                drive_cycle(r[2:0] != 3'd0, x, y, r[5:3] != 3'd0, r[7:6] == 2'd0);
                if (r[2:0] != 3'd0) begin
                    sent++;
                end
            end
            drain_pipeline();
        end
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        pix_valid   = 1'b0;
        pix         = '0;
        frame_start = 1'b0;
        cycle       = 0;
        errors      = 0;
        checks      = 0;
        rng_state   = 32'hd236_f7e1;
        p_count     = 0;
        g_count     = 0;
        p_frame     = 1'b0;
        g_frame     = 1'b0;
        clear_scene();

        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        arst_n = 1'b1;

        check_reset_and_blank();
        sweep_tiles();
        turn_player();
        overlap_ghosts();
        switch_game_state();
        random_sweep();

        report_counts();
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
